// ==== cam_cfg_pkg.sv ====
package cam_cfg_pkg;

   // sensor addressing
   localparam logic [7:0]  SENSOR_DEV_ADDR = 8'h6C;
   localparam logic [15:0] ID_REG_ADDR     = 16'h300B;  // chip id register
   localparam logic [7:0]  EXPECTED_ID     = 8'h88;
   localparam logic [7:0]  DELAY_MARK      = 8'hAA;     // dev field of a delay entry

   // table and timing
   localparam int TABLE_LEN  = 13;
   localparam int XFER_GAP   = 4;   // idle cycles after each transfer
   localparam int RETRY_GAP  = 16;  // idle cycles after a bad id
   localparam int DELAY_UNIT = 4;   // cycles per delay count

   // widths
   localparam int IDX_W   = 4;
   localparam int TMR_W   = 12;
   localparam int DATA_W  = 8;
   localparam int PADDR_W = 24;     // dev address + register address

   // one table line, dev / register / data
   typedef struct packed {
      logic [7:0]        dev;       // device address or DELAY_MARK
      logic [15:0]       reg_addr;
      logic [DATA_W-1:0] value;     // write data or delay count
   } cfg_entry_t;

   // requester side of the bus
   typedef struct packed {
      logic               psel;
      logic               penable;
      logic               pwrite;
      logic [PADDR_W-1:0] paddr;
      logic [DATA_W-1:0]  pwdata;
   } apb_req_t;

   // completer side of the bus
   typedef struct packed {
      logic              pready;
      logic [DATA_W-1:0] prdata;
   } apb_rsp_t;

endpackage

// ==== cam_cfg_rom.sv ====
`timescale 1ns/1ps

module cam_cfg_rom (
   input  logic                          CLK_400K,
   input  logic [cam_cfg_pkg::IDX_W-1:0] rom_idx,
   output cam_cfg_pkg::cfg_entry_t       entry
);
   import cam_cfg_pkg::*;

   // registered lookup, entry follows rom_idx by one cycle
   always_ff @(posedge CLK_400K) begin
      case (rom_idx)
         0: begin
            entry <= {SENSOR_DEV_ADDR, 16'h0103, 8'h01};  // software reset
         end
         1: begin
            entry <= {DELAY_MARK, 16'h0000, 8'd10};       // let the reset settle
         end
         2: begin
            entry <= {SENSOR_DEV_ADDR, 16'h0100, 8'h00};  // standby
         end
         3: begin
            entry <= {SENSOR_DEV_ADDR, 16'h0302, 8'h18};  // pll1 multiplier
         end
         4: begin
            entry <= {SENSOR_DEV_ADDR, 16'h0303, 8'h00};  // pll1 pre divider
         end
         5: begin
            entry <= {SENSOR_DEV_ADDR, 16'h0304, 8'h03};  // pll1 mipi divider
         end
         6: begin
            entry <= {SENSOR_DEV_ADDR, 16'h3018, 8'h72};  // mipi 4 lane
         end
         7: begin
            entry <= {SENSOR_DEV_ADDR, 16'h3808, 8'h02};  // x size high
         end
         8: begin
            entry <= {SENSOR_DEV_ADDR, 16'h3809, 8'h80};  // x size low, 640
         end
         9: begin
            entry <= {SENSOR_DEV_ADDR, 16'h380A, 8'h01};  // y size high
         end
         10: begin
            entry <= {SENSOR_DEV_ADDR, 16'h380B, 8'hE0};  // y size low, 480
         end
         11: begin
            entry <= {DELAY_MARK, 16'h0000, 8'd10};
         end
         12: begin
            entry <= {SENSOR_DEV_ADDR, 16'h0100, 8'h01};  // stream on
         end
         default: begin
            entry <= '0;                                  // past the end
         end
      endcase
   end

endmodule

// ==== cam_cfg_timer.sv ====
`timescale 1ns/1ps

module cam_cfg_timer (
   input  logic                          CLK_400K,
   input  logic                          RESET_N,
   input  logic                          tmr_load,
   input  logic [cam_cfg_pkg::TMR_W-1:0] tmr_count,
   output logic                          tmr_expired
);
   import cam_cfg_pkg::*;

   logic [TMR_W-1:0] cnt;

   // expired rises tmr_count cycles after the load edge
   // and holds until the next load
   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         cnt         <= '0;
         tmr_expired <= 1'b0;
      end else if (tmr_load) begin
         cnt         <= tmr_count;
         tmr_expired <= (tmr_count == '0);  // zero count expires at once
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
         if (cnt == TMR_W'(1)) begin
            tmr_expired <= 1'b1;
         end
      end
   end

endmodule

// ==== cam_cfg_apb_master.sv ====
`timescale 1ns/1ps

module cam_cfg_apb_master (
   input  logic                           CLK_400K,
   input  logic                           RESET_N,
   input  logic                           xfer_start,
   input  logic                           xfer_write,
   input  cam_cfg_pkg::cfg_entry_t        xfer_entry,
   output logic                           xfer_done,
   output logic [cam_cfg_pkg::DATA_W-1:0] rd_data,
   output cam_cfg_pkg::apb_req_t          apb_req,
   input  cam_cfg_pkg::apb_rsp_t          apb_rsp
);
   import cam_cfg_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS
   } apb_state_t;

   apb_state_t         state;
   logic [PADDR_W-1:0] paddr_q;
   logic               pwrite_q;
   logic [DATA_W-1:0]  pwdata_q;
   logic               complete;

   assign complete = (state == ST_ACCESS) && apb_rsp.pready;

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state     <= ST_IDLE;
         xfer_done <= 1'b0;
      end else begin
         xfer_done <= complete;          // one pulse per transfer
         case (state)
            ST_IDLE:   if (xfer_start) state <= ST_SETUP;
            ST_SETUP:  state <= ST_ACCESS;
            ST_ACCESS: if (apb_rsp.pready) state <= ST_IDLE;  // else hold
            default:   state <= ST_IDLE;
         endcase
      end
   end

   // address and data held from setup to completion
   always_ff @(posedge CLK_400K) begin
      if (state == ST_IDLE && xfer_start) begin
         paddr_q  <= {xfer_entry.dev, xfer_entry.reg_addr};
         pwrite_q <= xfer_write;
         pwdata_q <= xfer_entry.value;
      end
      if (complete && !pwrite_q) begin
         rd_data <= apb_rsp.prdata;      // sampled at the completion edge
      end
   end

   always_comb begin
      apb_req.psel    = (state != ST_IDLE);
      apb_req.penable = (state == ST_ACCESS);
      apb_req.pwrite  = pwrite_q;
      apb_req.paddr   = paddr_q;
      apb_req.pwdata  = pwdata_q;
   end

endmodule

// ==== cam_cfg_fsm.sv ====
`timescale 1ns/1ps

module cam_cfg_fsm (
   input  logic                           CLK_400K,
   input  logic                           RESET_N,
   input  cam_cfg_pkg::cfg_entry_t        entry,
   output logic [cam_cfg_pkg::IDX_W-1:0]  rom_idx,
   output logic                           xfer_start,
   output logic                           xfer_write,
   output cam_cfg_pkg::cfg_entry_t        xfer_entry,
   input  logic                           xfer_done,
   input  logic [cam_cfg_pkg::DATA_W-1:0] rd_data,
   output logic                           tmr_load,
   output logic [cam_cfg_pkg::TMR_W-1:0]  tmr_count,
   input  logic                           tmr_expired,
   output logic                           camera_ready
);
   import cam_cfg_pkg::*;

   typedef enum logic [2:0] {
      S_ID_REQ,
      S_ID_WAIT,
      S_ID_GAP,
      S_FETCH,
      S_DECODE,
      S_WR_WAIT,
      S_GAP,
      S_DONE
   } fsm_state_t;

   fsm_state_t state;
   logic       id_ok;
   logic       gap_over;

   // expired is stale while the load pulse is still on its way
   assign gap_over = tmr_expired && !tmr_load;

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state        <= S_ID_REQ;
         rom_idx      <= '0;
         xfer_start   <= 1'b0;
         tmr_load     <= 1'b0;
         id_ok        <= 1'b0;
         camera_ready <= 1'b0;
      end else begin
         xfer_start <= 1'b0;
         tmr_load   <= 1'b0;
         case (state)
            S_ID_REQ: begin
               xfer_start <= 1'b1;
               xfer_write <= 1'b0;
               xfer_entry <= {SENSOR_DEV_ADDR, ID_REG_ADDR, 8'h00};  // id read
               state      <= S_ID_WAIT;
            end
            S_ID_WAIT: begin
               if (xfer_done) begin
                  tmr_load <= 1'b1;
                  id_ok    <= (rd_data == EXPECTED_ID);
                  if (rd_data == EXPECTED_ID) begin
                     tmr_count <= TMR_W'(XFER_GAP);
                  end else begin
                     tmr_count <= TMR_W'(RETRY_GAP);                    // wrong part or asleep
                  end
                  state <= S_ID_GAP;
               end
            end
            S_ID_GAP: begin
               if (gap_over) begin
                  state <= id_ok ? S_FETCH : S_ID_REQ;
               end
            end
            S_FETCH: begin
               state <= S_DECODE;                 // rom output lags one cycle
            end
            S_DECODE: begin
               if (entry.dev == DELAY_MARK) begin
                  tmr_load  <= 1'b1;
                  tmr_count <= TMR_W'(entry.value) * TMR_W'(DELAY_UNIT);
                  state     <= S_GAP;
               end else begin
                  xfer_start <= 1'b1;
                  xfer_write <= 1'b1;
                  xfer_entry <= entry;
                  state      <= S_WR_WAIT;
               end
            end
            S_WR_WAIT: begin
               if (xfer_done) begin
                  tmr_load  <= 1'b1;
                  tmr_count <= TMR_W'(XFER_GAP);
                  state     <= S_GAP;
               end
            end
            S_GAP: begin
               if (gap_over) begin
                  if (rom_idx == IDX_W'(TABLE_LEN - 1)) begin
                     camera_ready <= 1'b1;         // held until reset
                     state        <= S_DONE;
                  end else begin
                     rom_idx <= rom_idx + 1'b1;
                     state   <= S_FETCH;
                  end
               end
            end
            S_DONE: begin
               state <= S_DONE;
            end
            default: begin
               state <= S_ID_REQ;
            end
         endcase
      end
   end

endmodule

// ==== cam_cfg_top.sv ====
`timescale 1ns/1ps

module cam_cfg_top (
   input  logic                  CLK_400K,
   input  logic                  RESET_N,
   input  cam_cfg_pkg::apb_rsp_t apb_rsp,
   output cam_cfg_pkg::apb_req_t apb_req,
   output logic                  camera_ready
);
   import cam_cfg_pkg::*;

   cfg_entry_t        entry;
   cfg_entry_t        xfer_entry;
   logic [IDX_W-1:0]  rom_idx;
   logic              xfer_start;
   logic              xfer_write;
   logic              xfer_done;
   logic [DATA_W-1:0] rd_data;
   logic              tmr_load;
   logic [TMR_W-1:0]  tmr_count;
   logic              tmr_expired;

   cam_cfg_fsm i_fsm (
      .CLK_400K     (CLK_400K),
      .RESET_N      (RESET_N),
      .entry        (entry),
      .rom_idx      (rom_idx),
      .xfer_start   (xfer_start),
      .xfer_write   (xfer_write),
      .xfer_entry   (xfer_entry),
      .xfer_done    (xfer_done),
      .rd_data      (rd_data),
      .tmr_load     (tmr_load),
      .tmr_count    (tmr_count),
      .tmr_expired  (tmr_expired),
      .camera_ready (camera_ready)
   );

   cam_cfg_rom i_rom (
      .CLK_400K (CLK_400K),
      .rom_idx  (rom_idx),
      .entry    (entry)
   );

   cam_cfg_timer i_timer (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .tmr_load    (tmr_load),
      .tmr_count   (tmr_count),
      .tmr_expired (tmr_expired)
   );

   cam_cfg_apb_master i_apb_master (
      .CLK_400K   (CLK_400K),
      .RESET_N    (RESET_N),
      .xfer_start (xfer_start),
      .xfer_write (xfer_write),
      .xfer_entry (xfer_entry),
      .xfer_done  (xfer_done),
      .rd_data    (rd_data),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp)
   );

endmodule

// ==== cam_cfg_assertions.sv ====
`timescale 1ns/1ps

module cam_cfg_assertions (
   input logic                  CLK_400K,
   input logic                  RESET_N,
   input cam_cfg_pkg::apb_req_t apb_req,
   input cam_cfg_pkg::apb_rsp_t apb_rsp,
   input logic                  camera_ready
);
   import cam_cfg_pkg::*;

   logic completing;

   assign completing = apb_req.psel && apb_req.penable && apb_rsp.pready;

   enable_needs_sel: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      apb_req.penable |-> apb_req.psel)
      else $error("penable high without psel");

   setup_to_access: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
      else $error("setup phase not followed by access phase");

   // address and data frozen until the completion edge
   hold_during_xfer: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      apb_req.psel && !completing |=> $stable(apb_req.paddr) && $stable(apb_req.pwrite)
                                      && $stable(apb_req.pwdata))
      else $error("address or data changed during a transfer");

   drop_after_done: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      completing |=> !apb_req.psel && !apb_req.penable)
      else $error("psel or penable still high after completion");

   ready_sticky: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      camera_ready |=> camera_ready)
      else $error("camera_ready fell before reset");

endmodule

bind cam_cfg_apb_master cam_cfg_assertions i_apb_checks (
   .CLK_400K     (CLK_400K),
   .RESET_N      (RESET_N),
   .apb_req      (apb_req),
   .apb_rsp      (apb_rsp),
   .camera_ready (1'b1)          // no ready flag at this level
);

bind cam_cfg_top cam_cfg_assertions i_top_checks (
   .CLK_400K     (CLK_400K),
   .RESET_N      (RESET_N),
   .apb_req      (apb_req),
   .apb_rsp      (apb_rsp),
   .camera_ready (camera_ready)
);

// ==== cam_cfg_tb.sv ====
`timescale 1ns/1ps

module cam_cfg_tb;
   import cam_cfg_pkg::*;

   localparam int RETRIES   = 2;
   localparam int RUN_LIMIT = 3 * (3 * (TABLE_LEN * (XFER_GAP + 6))
                                   + 2 * 10 * DELAY_UNIT + RETRY_GAP * RETRIES);

   // dev AA in the top byte marks a delay entry
   localparam logic [31:0] CFG_TABLE [0:12] = '{
      32'h6C_0103_01, 32'hAA_0000_0A, 32'h6C_0100_00, 32'h6C_0302_18,
      32'h6C_0303_00, 32'h6C_0304_03, 32'h6C_3018_72, 32'h6C_3808_02,
      32'h6C_3809_80, 32'h6C_380A_01, 32'h6C_380B_E0, 32'hAA_0000_0A,
      32'h6C_0100_01
   };

   logic        CLK_400K;
   logic        RESET_N;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   logic        camera_ready;

   int          cycle = 0;
   int          run_cycles = 0;
   string       test_name = "init";
   logic        stall_en;
   int          bad_reads;          // reads answered with a wrong id
   logic [7:0]  sensor_id;
   int          wait_left;
   int          cur_setup;
   logic        busy;
   logic [23:0] rd_addr[$];
   int          rd_setup[$];
   int          rd_done[$];
   logic [23:0] wr_addr[$];
   logic [7:0]  wr_data[$];
   int          wr_setup[$];
   int          wr_done[$];

   cam_cfg_top i_cam_cfg_top (
      .CLK_400K     (CLK_400K),
      .RESET_N      (RESET_N),
      .apb_rsp      (apb_rsp),
      .apb_req      (apb_req),
      .camera_ready (camera_ready)
   );

   initial CLK_400K = 1'b0;
   always #10 CLK_400K = ~CLK_400K;

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s: expected 'h%0h, actual 'h%0h", test_name, what,
                  expected, actual);
         $display("Test failed");
         $fatal(1, "check failed");
      end
   endtask

   // returns floor_val when value reaches it, so a short gap shows up as a mismatch
   function automatic int at_least(input int value, input int floor_val);
      return (value >= floor_val) ? floor_val : value;
   endfunction

   always @(posedge CLK_400K) begin
      cycle <= cycle + 1;
      if (!RESET_N) begin
         run_cycles <= 0;
      end else begin
         run_cycles <= run_cycles + 1;
      end
      if (run_cycles > RUN_LIMIT) begin
         $display("%s: run did not finish in time", test_name);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   // sensor model behind the APB completer
   always @(posedge CLK_400K) begin
      if (!RESET_N) begin
         apb_rsp.pready <= 1'b0;
         busy = 1'b0;
      end else if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
         busy = 1'b0;
         apb_rsp.pready <= 1'b0;
         if (apb_req.pwrite) begin
            wr_addr.push_back(apb_req.paddr);
            wr_data.push_back(apb_req.pwdata);
            wr_setup.push_back(cur_setup);
            wr_done.push_back(cycle);
         end else begin
            rd_addr.push_back(apb_req.paddr);
            rd_setup.push_back(cur_setup);
            rd_done.push_back(cycle);
         end
      end else if (apb_req.psel && !apb_req.penable) begin
         check_value("one transfer at a time", 32'd0, busy);
         busy = 1'b1;
         cur_setup = cycle;
         wait_left = stall_en ? $urandom_range(3, 0) : 0;
         apb_rsp.pready <= (wait_left == 0);
         apb_rsp.prdata <= (rd_done.size() < bad_reads) ? 8'h00 : sensor_id;
      end else if (apb_req.psel) begin
         wait_left = wait_left - 1;          // stalled access phase
         apb_rsp.pready <= (wait_left == 0);
      end
   end

   task automatic reset_dut(input string name, input logic stalls, input int bad);
      test_name = name;
      stall_en  = stalls;
      bad_reads = bad;
      @(posedge CLK_400K);
      RESET_N <= 1'b0;
      rd_addr.delete();
      rd_setup.delete();
      rd_done.delete();
      wr_addr.delete();
      wr_data.delete();
      wr_setup.delete();
      wr_done.delete();
      repeat (2) @(posedge CLK_400K);
      RESET_N <= 1'b1;
   endtask

   task automatic wait_ready();
      while (camera_ready !== 1'b1) begin
         @(negedge CLK_400K);
      end
   endtask

   task automatic compare_writes();
      int n;
      int i;
      n = 0;
      check_value("write count", 32'd11, wr_addr.size());
      for (i = 0; i < 13; i++) begin
         if (CFG_TABLE[i][31:24] != 8'hAA) begin
            check_value("write address", CFG_TABLE[i][31:8], wr_addr[n]);
            check_value("write data", CFG_TABLE[i][7:0], wr_data[n]);
            n++;
         end
      end
   endtask

   task automatic test_id_then_writes();
      reset_dut("test_id_then_writes", 1'b0, 0);
      wait_ready();
      check_value("read count", 32'd1, rd_addr.size());
      check_value("id read address", 24'h6C300B, rd_addr[0]);
      check_value("read comes first", 32'd1, rd_done[0] < wr_setup[0]);
      compare_writes();
   endtask

   task automatic test_id_retry();
      int i;
      reset_dut("test_id_retry", 1'b0, RETRIES);
      wait_ready();
      check_value("read count", RETRIES + 1, rd_addr.size());
      for (i = 1; i <= RETRIES; i++) begin
         check_value("retry gap", RETRY_GAP,
                     at_least(rd_setup[i] - rd_done[i-1] - 1, RETRY_GAP));
      end
      check_value("first write after id", rd_done[RETRIES] + 1,
                  at_least(wr_setup[0], rd_done[RETRIES] + 1));
      compare_writes();
   endtask

   task automatic test_delay_entries();
      int min_idle;
      reset_dut("test_delay_entries", 1'b0, 0);
      wait_ready();
      min_idle = 10 * DELAY_UNIT + XFER_GAP;
      check_value("write count", 32'd11, wr_addr.size());
      check_value("delay after soft reset", min_idle,
                  at_least(wr_setup[1] - wr_done[0] - 1, min_idle));
      check_value("delay before stream on", min_idle,
                  at_least(wr_setup[10] - wr_done[9] - 1, min_idle));
   endtask

   task automatic test_backpressure();
      reset_dut("test_backpressure", 1'b1, 0);
      wait_ready();
      compare_writes();                      // overlap is checked in the model
   endtask

   task automatic test_ready_flag();
      int total;
      reset_dut("test_ready_flag", 1'b0, 0);
      @(negedge CLK_400K);
      check_value("ready after reset", 32'd0, camera_ready);
      while (wr_done.size() < 11) begin
         check_value("ready before last write", 32'd0, camera_ready);
         @(negedge CLK_400K);
      end
      wait_ready();
      check_value("gap before ready", XFER_GAP,
                  at_least(cycle - wr_done[10] - 1, XFER_GAP));
      total = rd_addr.size() + wr_addr.size();
      repeat (50) @(negedge CLK_400K);
      check_value("transfers after ready", total, rd_addr.size() + wr_addr.size());
      check_value("ready holds", 32'd1, camera_ready);
   endtask

   initial begin
      RESET_N   <= 1'b0;
      apb_rsp   <= '0;
      stall_en  = 1'b0;
      bad_reads = 0;
      sensor_id = 8'h88;                     // matching chip id
      busy      = 1'b0;
      void'($urandom(70592));
      test_id_then_writes();
      test_id_retry();
      test_delay_entries();
      test_backpressure();
      test_ready_flag();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== all.f ====
cam_cfg_pkg.sv
cam_cfg_rom.sv
cam_cfg_timer.sv
cam_cfg_apb_master.sv
cam_cfg_fsm.sv
cam_cfg_top.sv
cam_cfg_assertions.sv
cam_cfg_tb.sv
